//--- alu.sv
// Combinational ALU
// Six logic and arithmetic operations, with a flag for codes it does not recognise
`timescale 1ns/10ps
`include "cpu_settings.svh"

module alu import cpuPkg::*; (
	input  aluOp_e              op,
	input  logic [`DATA_W-1:0]  a,
	input  logic [`DATA_W-1:0]  b,
	output logic [`DATA_W-1:0]  result,
	output logic                known
);

	always_comb begin
		known  = 1'b1;
		result = '0;
		case (op)
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_ADD: result = a + b;
			// Wraps modulo 2^DATA_W like ADD
			ALU_SUB: result = a - b;
			// MOV ignores a and copies the second operand
			ALU_MOV: result = b;
			default: begin
				// Cleared so the FSM retires the instruction as a no-op
				known = 1'b0;
			end
		endcase
	end

endmodule

//--- controlFsm.sv
// Multicycle control FSM
// Sequences fetch, decode and execute, and decodes load and store from the latched word
`timescale 1ns/10ps

module controlFsm import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic aluKnown,
	ctrlIf.fsm  ctrl
);

	fsmState_e state;
	fsmState_e nextState;
	logic      isLoad;
	logic      isStore;
	logic      isIFormat;

	// Load and store share one major opcode and are told apart by the R-view extension
	assign isLoad    = (ctrl.instr.r.op == MAJ_LDST) && (ctrl.instr.r.opExt == EXT_LOAD);
	assign isStore   = (ctrl.instr.r.op == MAJ_LDST) && (ctrl.instr.r.opExt == EXT_STORE);
	// Every major opcode other than R selects the immediate view
	assign isIFormat = (ctrl.instr.r.op != MAJ_RTYPE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = FETCH;
		case (state)
			FETCH:  nextState = DECODE;
			// Anything that is neither load nor store goes through EXEC
			DECODE: nextState = isLoad ? LOAD1 : (isStore ? STORE : EXEC);
			LOAD1:  nextState = LOAD2;
			default: nextState = FETCH;
		endcase
	end

	// Moore outputs, except that an unknown ALU code suppresses the EXEC write
	always_comb begin
		ctrl.irLoad   = 1'b0;
		ctrl.pcEnable = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.immSel   = 1'b0;
		ctrl.addrSel  = 1'b0;
		ctrl.wbSel    = 1'b0;
		ctrl.memWe    = 1'b0;
		case (state)
			FETCH: ctrl.irLoad = 1'b1;
			EXEC: begin
				ctrl.immSel   = isIFormat;
				ctrl.regWrite = aluKnown;
				ctrl.pcEnable = 1'b1;
			end
			STORE: begin
				ctrl.addrSel  = 1'b1;
				ctrl.memWe    = 1'b1;
				ctrl.pcEnable = 1'b1;
			end
			// Address from rSrc is held over both load cycles
			LOAD1: ctrl.addrSel = 1'b1;
			LOAD2: begin
				ctrl.addrSel  = 1'b1;
				ctrl.wbSel    = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.pcEnable = 1'b1;
			end
			default: ;
		endcase
	end

	stateLegal: assert property (@(posedge clk) disable iff (rst)
		state inside {FETCH, DECODE, EXEC, STORE, LOAD1, LOAD2});

	weOnlyInStore: assert property (@(posedge clk) disable iff (rst)
		ctrl.memWe |-> state == STORE);

	// A store always returns to FETCH, so the strobe can never stretch
	storeSingle: assert property (@(posedge clk) disable iff (rst)
		state == STORE |=> state != STORE);

endmodule

//--- cpuDatapath.sv
// CPU datapath
// Program counter, instruction register and operand, address and write-back selection
// around the ALU and the register file
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuDatapath import cpuPkg::*; (
	input  logic                clk,
	input  logic                rst,
	ctrlIf.datapath             ctrl,
	input  logic [`DATA_W-1:0]  memRData,
	output logic [`DATA_W-1:0]  memAddr,
	output logic [`DATA_W-1:0]  memWData,
	output logic                aluKnown
);

	logic [`DATA_W-1:0] pc;
	instr_u             ir;
	logic [`DATA_W-1:0] rDataA;
	logic [`DATA_W-1:0] rDataB;
	logic [`DATA_W-1:0] immExt;
	logic [`DATA_W-1:0] aluB;
	logic [`DATA_W-1:0] aluResult;
	logic [`DATA_W-1:0] wbData;
	aluOp_e             aluOp;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (ctrl.pcEnable) begin
			pc <= pc + 1'b1;
		end
	end

	// The instruction word is only decoded after FETCH has loaded it
	always_ff @(posedge clk) begin
		if (ctrl.irLoad) begin
			ir <= memRData;
		end
	end

	assign ctrl.instr = ir;

	// Immediate is zero-extended to the full word
	assign immExt = {{(`DATA_W - 8){1'b0}}, ir.i.imm};

	// I format takes its operation from the top field, R format from the extension
	assign aluOp = ctrl.immSel ? ir.i.op : aluOp_e'(ir.r.opExt);
	assign aluB  = ctrl.immSel ? immExt : rDataB;

	// rDest is read on port A and rSrc on port B
	regFile uRegFile (
		.clk    (clk),
		.rst    (rst),
		.we     (ctrl.regWrite),
		.wAddr  (ir.r.rDest),
		.wData  (wbData),
		.rAddrA (ir.r.rDest),
		.rAddrB (ir.r.rSrc),
		.rDataA (rDataA),
		.rDataB (rDataB)
	);

	alu uAlu (
		.op     (aluOp),
		.a      (rDataA),
		.b      (aluB),
		.result (aluResult),
		.known  (aluKnown)
	);

	// Loads and stores address memory through rSrc, fetches through the PC
	assign memAddr  = ctrl.addrSel ? rDataB : pc;
	// Store data is always rDest and only matters while memWe is high
	assign memWData = rDataA;
	assign wbData   = ctrl.wbSel ? memRData : aluResult;

endmodule

//--- cpuPkg.sv
// CPU shared types
// Opcode encodings, the two instruction formats and the state encoding of the control FSM
package cpuPkg;

	// ALU operation code, used as the I-format opcode and as the R-format extension
	typedef enum logic [3:0] {
		ALU_AND = 4'b0001,
		ALU_OR  = 4'b0010,
		ALU_XOR = 4'b0011,
		ALU_ADD = 4'b0101,
		ALU_SUB = 4'b1001,
		ALU_MOV = 4'b1101
	} aluOp_e;

	// Top field of the instruction word
	// Values that match an ALU code select the immediate form of that operation
	typedef enum logic [3:0] {
		MAJ_RTYPE = 4'b0000,
		MAJ_ANDI  = 4'b0001,
		MAJ_ORI   = 4'b0010,
		MAJ_XORI  = 4'b0011,
		MAJ_LDST  = 4'b0100,
		MAJ_ADDI  = 4'b0101,
		MAJ_SUBI  = 4'b1001,
		MAJ_MOVI  = 4'b1101
	} majorOp_e;

	// Extension codes that split the load/store major opcode
	localparam logic [3:0] EXT_LOAD  = 4'b0000;
	localparam logic [3:0] EXT_STORE = 4'b0100;

	// Register format: op, rDest, opExt, rSrc
	typedef struct packed {
		majorOp_e   op;
		logic [3:0] rDest;
		logic [3:0] opExt;
		logic [3:0] rSrc;
	} rInstr_t;

	// Immediate format, the 8-bit immediate is zero-extended on use
	typedef struct packed {
		aluOp_e     op;
		logic [3:0] rDest;
		logic [7:0] imm;
	} iInstr_t;

	// One fetched word, read through whichever view the major opcode calls for
	typedef union packed {
		rInstr_t r;
		iInstr_t i;
	} instr_u;

	// Control FSM states
	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXEC,
		STORE,
		LOAD1,
		LOAD2
	} fsmState_e;

endpackage

//--- cpuTop.sv
// CPU top level
// Joins the control FSM and the datapath, with plain ports to a unified memory
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuTop (
	input  logic                clk,
	input  logic                rst,
	input  logic [`DATA_W-1:0]  memRData,
	output logic [`DATA_W-1:0]  memAddr,
	output logic [`DATA_W-1:0]  memWData,
	output logic                memWe
);

	logic aluKnown;

	ctrlIf ctrlBus ();

	controlFsm uFsm (
		.clk      (clk),
		.rst      (rst),
		.aluKnown (aluKnown),
		.ctrl     (ctrlBus)
	);

	cpuDatapath uDatapath (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrlBus),
		.memRData (memRData),
		.memAddr  (memAddr),
		.memWData (memWData),
		.aluKnown (aluKnown)
	);

	// The store strobe leaves straight from the FSM
	assign memWe = ctrlBus.memWe;

endmodule

//--- cpu_settings.svh
// CPU sizing macros
// Word width and register file geometry, fixed by the 16-bit instruction format
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data, address and instruction words all share one width
`define DATA_W 16

// General register count
`define REG_COUNT 16

// Register address width, matching the 4-bit register fields of both formats
`define REG_AW 4

`endif

//--- ctrlIf.sv
// Control bus between the FSM and the datapath
// Strobes flow toward the datapath and the latched instruction comes back
`timescale 1ns/10ps

interface ctrlIf import cpuPkg::*; ();

	// All strobes are single-cycle levels decoded from the FSM state
	logic irLoad;
	logic pcEnable;
	logic regWrite;
	logic immSel;
	logic addrSel;
	logic wbSel;
	logic memWe;

	// Instruction register contents, decoded by the FSM
	instr_u instr;

	modport fsm (
		output irLoad, pcEnable, regWrite, immSel, addrSel, wbSel, memWe,
		input  instr
	);

	modport datapath (
		input  irLoad, pcEnable, regWrite, immSel, addrSel, wbSel, memWe,
		output instr
	);

endinterface

//--- list.f
+incdir+.
cpuPkg.sv
ctrlIf.sv
controlFsm.sv
alu.sv
regFile.sv
cpuDatapath.sv
cpuTop.sv
tbCpu.sv

//--- regFile.sv
// General register file
// Sixteen words, two asynchronous read ports and one synchronous write port
`timescale 1ns/10ps
`include "cpu_settings.svh"

module regFile (
	input  logic                clk,
	input  logic                rst,
	input  logic                we,
	input  logic [`REG_AW-1:0]  wAddr,
	input  logic [`DATA_W-1:0]  wData,
	input  logic [`REG_AW-1:0]  rAddrA,
	input  logic [`REG_AW-1:0]  rAddrB,
	output logic [`DATA_W-1:0]  rDataA,
	output logic [`DATA_W-1:0]  rDataB
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	// All registers read as zero after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wAddr] <= wData;
		end
	end

	// Reads see the old value during a write cycle
	assign rDataA = regs[rAddrA];
	assign rDataB = regs[rAddrB];

	wAddrKnown: assert property (@(posedge clk) disable iff (rst)
		we |-> !$isunknown(wAddr));

endmodule

//--- run.sh
#!/bin/sh
# Builds the CPU testbench with Verilator, runs it and checks the log for the pass message
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbCpu -f list.f -o tbCpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tbCpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
	exit 0
fi
exit 1

//--- tbProgram.svh
// Program builder and shadow model for the CPU testbench
// Assembles the test program in memory and queues each store it should make
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// One 32-bit xorshift step, low byte used as the operand
function automatic logic [7:0] nextRand();
	rngState ^= rngState << 13;
	rngState ^= rngState >> 17;
	rngState ^= rngState << 5;
	return rngState[7:0];
endfunction

// ISA result with rDest as operand a, an unknown code leaves rDest as it was
function automatic logic [15:0] modelAlu(logic [3:0] op, logic [15:0] a, logic [15:0] b);
	case (op)
		4'b0001: return a & b;
		4'b0010: return a | b;
		4'b0011: return a ^ b;
		4'b0101: return a + b;
		4'b1001: return a - b;
		4'b1101: return b;
		default: return a;
	endcase
endfunction

function automatic instr_u rFormat(logic [3:0] major, logic [3:0] rd, logic [3:0] ext,
	logic [3:0] rs);
	instr_u w;
	w.r.op    = majorOp_e'(major);
	w.r.rDest = rd;
	w.r.opExt = ext;
	w.r.rSrc  = rs;
	return w;
endfunction

task automatic emit(instr_u word);
	mem[progLen] = word;
	progLen++;
endtask

// Immediate operation, the 8-bit immediate is zero-extended
task automatic immOp(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
	instr_u w;
	w.i.op    = aluOp_e'(op);
	w.i.rDest = rd;
	w.i.imm   = imm;
	emit(w);
	shadow[rd] = modelAlu(op, shadow[rd], {8'h00, imm});
endtask

task automatic regOp(logic [3:0] ext, logic [3:0] rd, logic [3:0] rs);
	emit(rFormat(4'b0000, rd, ext, rs));
	shadow[rd] = modelAlu(ext, shadow[rd], shadow[rs]);
endtask

// r15 is kept free as the address register for loads and stores
task automatic loadWord(logic [3:0] rd, logic [7:0] addr);
	immOp(4'b1101, 4'hF, addr);
	emit(rFormat(4'b0100, rd, 4'b0000, 4'hF));
	shadow[rd] = mem[addr];
endtask

// Stores r0 to r7 into the next free slots from address 200 upward
task automatic storeRegs(int test);
	logic [7:0] addr;
	for (int r = 0; r < 8; r++) begin
		addr = 8'd200 + storeSlot[7:0];
		immOp(4'b1101, 4'hF, addr);
		emit(rFormat(4'b0100, r[3:0], 4'b0100, 4'hF));
		qAddr.push_back({8'h00, addr});
		qData.push_back(shadow[r]);
		qTest.push_back(test);
		storeSlot++;
	end
endtask

task automatic buildProgram();
	logic [7:0] pick;
	// Zero words decode as R format with an unknown extension, so free memory is no-ops
	for (int addr = 0; addr < 256; addr++) begin
		mem[addr] = '0;
	end
	// Load data region, each word built from its full address
	for (int addr = 160; addr < 192; addr++) begin
		mem[addr] = {addr[7:0] ^ 8'h5A, ~addr[7:0]};
	end
	for (int r = 0; r < `REG_COUNT; r++) begin
		shadow[r] = '0;
	end
	progLen   = 0;
	storeSlot = 0;
	for (int r = 0; r < 8; r++) begin
		immOp(4'b1101, r[3:0], nextRand());
	end
	for (int k = 0; k < 6; k++) begin
		pick = nextRand();
		immOp(aluCodes[k], {1'b0, pick[2:0]}, nextRand());
	end
	storeRegs(2);
	for (int k = 0; k < 6; k++) begin
		pick = nextRand();
		regOp(aluCodes[k], {1'b0, pick[2:0]}, {1'b0, pick[6:4]});
	end
	// Zero minus five has to wrap around
	immOp(4'b1101, 4'd6, 8'h00);
	immOp(4'b1101, 4'd7, 8'h05);
	regOp(4'b1001, 4'd6, 4'd7);
	storeRegs(3);
	for (int k = 0; k < 4; k++) begin
		pick = nextRand();
		loadWord({1'b0, pick[2:0]}, 8'd160 + {3'b000, pick[7:3]});
	end
	storeRegs(4);
	// Unknown I opcode and unknown R extension
	immOp(4'b1111, 4'd2, nextRand());
	regOp(4'b0111, 4'd3, 4'd4);
	storeRegs(6);
	timeoutLimit = 4 * progLen + 64;
	updateHead();
endtask

`endif

//--- tbCpu.sv
// CPU testbench
// Runs a generated program on a combinational memory, stores and timing checked by assertions
`timescale 1ns/10ps
`include "cpu_settings.svh"

module tbCpu import cpuPkg::*; ();

	logic               clk;
	logic               rst;
	logic [`DATA_W-1:0] memRData;
	logic [`DATA_W-1:0] memAddr;
	logic [`DATA_W-1:0] memWData;
	logic               memWe;

	logic [`DATA_W-1:0] mem [256];
	logic [`DATA_W-1:0] shadow [`REG_COUNT];
	logic [31:0]        rngState = 32'd14;
	logic [3:0]         aluCodes [6] = '{4'b0001, 4'b0010, 4'b0011, 4'b0101, 4'b1001, 4'b1101};
	int                 progLen;
	int                 storeSlot;
	int unsigned        timeoutLimit;
	int unsigned        cycle = 0;

	// Expected stores in program order, the head is what the next memWe must show
	logic [`DATA_W-1:0] qAddr [$];
	logic [`DATA_W-1:0] qData [$];
	int                 qTest [$];
	logic               headValid;
	logic [`DATA_W-1:0] headAddr;
	logic [`DATA_W-1:0] headData;
	int                 headTest;
	int                 doneTest;

	logic               resetSeen = 1'b0;
	logic               weSeen = 1'b0;
	logic               fetchSeen = 1'b0;
	logic               fetchNow;
	logic [`DATA_W-1:0] lastFetchAddr;
	int unsigned        lastFetchCycle;
	int unsigned        expPeriod;
	int                 failures [7];
	int                 passCount = 0;
	int                 failCount = 0;

	`include "tbProgram.svh"

	cpuTop u_cpuTop (
		.clk      (clk),
		.rst      (rst),
		.memRData (memRData),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memWe    (memWe)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Memory answers in the same cycle and takes stores at the clock edge
	assign memRData = mem[memAddr[7:0]];
	always @(posedge clk) begin
		if (!rst && memWe) begin
			mem[memAddr[7:0]] <= memWData;
		end
	end

	function automatic string testName(int id);
		case (id)
			1: return "reset";
			2: return "immediate ops";
			3: return "register ops";
			4: return "load then store";
			5: return "timing";
			default: return "unknown opcode";
		endcase
	endfunction

	// Loads take one cycle more than every other instruction
	function automatic int unsigned periodOf(logic [15:0] word);
		return (word[15:12] == 4'b0100 && word[7:4] == 4'b0000) ? 4 : 3;
	endfunction

	task automatic updateHead();
		headValid = qAddr.size() > 0;
		if (headValid) begin
			headAddr = qAddr[0];
			headData = qData[0];
			headTest = qTest[0];
		end
	endtask

	task automatic reportTest(int id);
		if (failures[id] == 0) begin
			passCount++;
			$display("test %0d %s: ok", id, testName(id));
		end else begin
			failCount++;
			$display("test %0d %s: %0d check(s) failed", id, testName(id), failures[id]);
		end
	endtask

	assign fetchNow = !rst && (u_cpuTop.uFsm.state == FETCH);

	// Cycle count, fetch history and the timeout
	always @(posedge clk) begin
		cycle  <= cycle + 1;
		weSeen <= memWe && !rst;
		if (rst) begin
			resetSeen <= 1'b1;
			fetchSeen <= 1'b0;
		end else if (fetchNow) begin
			fetchSeen      <= 1'b1;
			lastFetchAddr  <= memAddr;
			lastFetchCycle <= cycle;
			expPeriod      <= periodOf(memRData);
		end
		if (cycle >= timeoutLimit) begin
			$display("timeout: %0d stores still missing after %0d cycles", qAddr.size(), cycle);
			$display("Regression failed");
			$finish;
		end
	end

	// A store is retired half a cycle after its checks, and its test reports with its last store
	always @(negedge clk) begin
		if (weSeen && headValid) begin
			doneTest = qTest.pop_front();
			void'(qAddr.pop_front());
			void'(qData.pop_front());
			updateHead();
			if (!headValid || headTest != doneTest) begin
				reportTest(doneTest);
			end
		end
	end

	resetHeld: assert property (@(posedge clk) rst && resetSeen |-> !memWe && memAddr == '0)
		else begin
			$display("error memAddr in reset: got %h, expected 0000 (memWe %h)",
				$sampled(memAddr), $sampled(memWe));
			failures[1]++;
		end

	resetRelease: assert property (@(posedge clk) $fell(rst) |-> !memWe && memAddr == '0)
		else begin
			$display("error memAddr after reset: got %h, expected 0000 (memWe %h)",
				$sampled(memAddr), $sampled(memWe));
			failures[1]++;
		end

	storeExpected: assert property (@(posedge clk) disable iff (rst) memWe |-> headValid)
		else begin
			$display("a store to %h happened after all expected stores", $sampled(memAddr));
			failures[5]++;
		end

	storeAddr: assert property (@(posedge clk) disable iff (rst)
		memWe && headValid |-> memAddr == headAddr)
		else begin
			$display("error memAddr: got %h, expected %h", $sampled(memAddr), headAddr);
			failures[headTest]++;
		end

	storeData: assert property (@(posedge clk) disable iff (rst)
		memWe && headValid |-> memWData == headData)
		else begin
			$display("error memWData: got %h, expected %h", $sampled(memWData), headData);
			failures[headTest]++;
		end

	weSingle: assert property (@(posedge clk) disable iff (rst) memWe |=> !memWe)
		else begin
			$display("memWe stayed high for more than one cycle");
			failures[5]++;
		end

	fetchStep: assert property (@(posedge clk) disable iff (rst)
		fetchNow && fetchSeen |-> memAddr == lastFetchAddr + 16'd1)
		else begin
			$display("error memAddr at fetch: got %h, expected %h", $sampled(memAddr),
				lastFetchAddr + 16'd1);
			failures[5]++;
		end

	fetchPeriod: assert property (@(posedge clk) disable iff (rst)
		fetchNow && fetchSeen |-> cycle - lastFetchCycle == expPeriod)
		else begin
			$display("instruction took %0d cycles between fetches, expected %0d",
				$sampled(cycle) - lastFetchCycle, expPeriod);
			failures[5]++;
		end

	initial begin
		rst = 1'b1;
		buildProgram();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// By this edge the first cycle out of reset has been checked
		@(negedge clk);
		reportTest(1);
		while (headValid) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		reportTest(5);
		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
